//--- common/isaPkg.sv
package isaPkg;

    // Instruction field widths
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;
    localparam int IMM_W    = 16;
    localparam int JADDR_W  = 26;

    // Primary opcode field values
    localparam logic [OPCODE_W-1:0] OPC_SPECIAL = 6'h00;
    localparam logic [OPCODE_W-1:0] OPC_J       = 6'h02;
    localparam logic [OPCODE_W-1:0] OPC_JAL     = 6'h03;
    localparam logic [OPCODE_W-1:0] OPC_BEQ     = 6'h04;
    localparam logic [OPCODE_W-1:0] OPC_BNE     = 6'h05;

    // Function field values under SPECIAL
    localparam logic [FUNCT_W-1:0] FN_JR   = 6'h08;
    localparam logic [FUNCT_W-1:0] FN_JALR = 6'h09;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;

    // Decoded instruction class
    typedef enum logic [31:0] {
        opNop,
        opAddu,
        opBeq,
        opBne,
        opJ,
        opJal,
        opJr,
        opJalr,
        opOther
    } opcodeT;

    // How an instruction affects the next PC
    typedef enum logic [1:0] {
        ifOrder,
        ifBranch,
        ifJump
    } ifuncT;

endpackage

//--- common/memMapPkg.sv
package memMapPkg;

    typedef logic [31:0] wordT;

    // Exception codes, same numbering as CP0 Cause.ExcCode
    typedef enum logic [4:0] {
        excNone     = 5'd0,
        excAddrLoad = 5'd4
    } excT;

    // Boot address of the instruction stream
    localparam wordT PC_BOOT = 32'h0000_3000;

    // Instruction memory window, both ends inclusive
    localparam wordT IM_START = 32'h0000_3000;
    localparam wordT IM_END   = 32'h0000_4ffc;

    // Fixed exception entry
    localparam wordT EXC_HANDLER = 32'h0000_4180;

endpackage

//--- fetch/programCounter.sv
`timescale 1ns/1ps

module programCounter import isaPkg::*, memMapPkg::*; #(
    parameter wordT BOOT_ADDR = PC_BOOT
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               en,
    input  opcodeT             instr,
    input  ifuncT              ifunc,
    input  logic               cmp,
    input  logic [IMM_W-1:0]   imm,
    input  logic [JADDR_W-1:0] jAddr,
    input  wordT               jReg,
    input  logic               exl,
    input  wordT               exnpc,
    output wordT               pc,
    output logic               bd,
    output excT                exc
);

    wordT branchTarget;
    wordT jumpTarget;
    wordT ctrlNpc;
    wordT nextPc;
    logic ctrlBd;

    // Branch seen in D while the delay slot fetch is still waiting
    logic holdBd;
    wordT holdNpc;

    // pc is already the delay slot address here
    assign branchTarget = pc + {{(30 - IMM_W){imm[IMM_W-1]}}, imm, 2'b00};
    assign jumpTarget   = {pc[31:JADDR_W+2], jAddr, 2'b00};

    // Set for every branch or jump class, taken or not
    assign ctrlBd = (ifunc == ifBranch) || (ifunc == ifJump);

    always_comb begin
        if (instr == opJr || instr == opJalr) begin
            ctrlNpc = jReg;
        end else if (instr == opJ || instr == opJal) begin
            ctrlNpc = jumpTarget;
        end else if (ifunc == ifBranch && cmp) begin
            ctrlNpc = branchTarget;
        end else begin
            ctrlNpc = pc + 32'd4;
        end
    end

    // Exception redirect wins over everything
    always_comb begin
        if (exl) begin
            nextPc = exnpc;
        end else if (holdBd) begin
            nextPc = holdNpc;
        end else begin
            nextPc = ctrlNpc;
        end
    end

    assign bd = ctrlBd || holdBd;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= BOOT_ADDR;
            holdBd <= 1'b0;
        end else if (en) begin
            pc     <= nextPc;
            holdBd <= 1'b0;
        end else if (ctrlBd) begin
            holdBd <= 1'b1;
        end
    end

    // Decode is only shown for one cycle, so keep its target
    always_ff @(posedge clk) begin
        if (!en && ctrlBd) begin
            holdNpc <= ctrlNpc;
        end
    end

    // Address error: outside the IM window or not word aligned
    always_comb begin
        if (pc < IM_START || pc > IM_END || pc[1:0] != 2'b00) begin
            exc = excAddrLoad;
        end else begin
            exc = excNone;
        end
    end

endmodule

//--- fetch/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import isaPkg::*, memMapPkg::*; #(
    parameter wordT BOOT_ADDR = PC_BOOT
) (
    input  logic               clk,
    input  logic               reset,
    // Next-PC controls from D
    input  opcodeT             instrD,
    input  ifuncT              ifuncD,
    input  logic               cmpD,
    input  logic [IMM_W-1:0]   immD,
    input  logic [JADDR_W-1:0] jAddrD,
    input  wordT               jRegD,
    // Exception redirect
    input  logic               exl,
    input  wordT               exnpc,
    // Instruction memory
    output wordT               iAddr,
    input  wordT               iRData,
    input  logic               iReady,
    // F/D register
    output wordT               codeD,
    output wordT               pcD,
    output logic               bdD,
    output excT                excD,
    output logic               validD,
    // Pipeline control
    input  logic               stall,
    input  logic               clear,
    input  logic               enPC,
    output logic               busyI,
    output excT                excF
);

    wordT pcF;
    logic bdF;

    programCounter #(
        .BOOT_ADDR(BOOT_ADDR)
    ) pcUnit (
        .clk(clk),
        .reset(reset),
        .en(enPC),
        .instr(instrD),
        .ifunc(ifuncD),
        .cmp(cmpD),
        .imm(immD),
        .jAddr(jAddrD),
        .jReg(jRegD),
        .exl(exl),
        .exnpc(exnpc),
        .pc(pcF),
        .bd(bdF),
        .exc(excF)
    );

    assign iAddr = pcF;
    assign busyI = ~iReady;

    // Control half of F/D, validD is high only right after a load
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            validD <= 1'b0;
            bdD    <= 1'b0;
            excD   <= excNone;
        end else if (!stall) begin
            validD <= 1'b1;
            bdD    <= bdF;
            excD   <= excF;
        end else begin
            validD <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            codeD <= '0;
            pcD   <= '0;
        end else if (!stall) begin
            // A faulting fetch enters D as a nop
            codeD <= (excF == excNone) ? iRData : '0;
            pcD   <= pcF;
        end
    end

endmodule

//--- verilog/branchDecode.sv
`timescale 1ns/1ps

module branchDecode import isaPkg::*, memMapPkg::*; (
    input  wordT               codeD,
    input  logic               validD,
    input  wordT               rsData,
    input  wordT               rtData,
    output logic [REG_W-1:0]   rsNum,
    output logic [REG_W-1:0]   rtNum,
    output opcodeT             instr,
    output ifuncT              ifunc,
    output logic               cmp,
    output logic [IMM_W-1:0]   imm,
    output logic [JADDR_W-1:0] jAddr,
    output wordT               jReg
);

    logic [OPCODE_W-1:0] opField;
    logic [FUNCT_W-1:0]  fnField;

    // Field split
    assign opField = codeD[31:32-OPCODE_W];
    assign fnField = codeD[FUNCT_W-1:0];
    assign rsNum   = codeD[25:21];
    assign rtNum   = codeD[20:16];
    assign imm     = codeD[IMM_W-1:0];
    assign jAddr   = codeD[JADDR_W-1:0];

    // jr and jalr take rs as target
    assign jReg = rsData;

    always_comb begin
        if (!validD || codeD == '0) begin
            instr = opNop;
        end else begin
            case (opField)
                OPC_SPECIAL: begin
                    case (fnField)
                        FN_ADDU: instr = opAddu;
                        FN_JR:   instr = opJr;
                        FN_JALR: instr = opJalr;
                        default: instr = opOther;
                    endcase
                end
                OPC_BEQ: instr = opBeq;
                OPC_BNE: instr = opBne;
                OPC_J:   instr = opJ;
                OPC_JAL: instr = opJal;
                default: instr = opOther;
            endcase
        end
    end

    // Function class from the decoded opcode
    always_comb begin
        case (instr)
            opBeq, opBne:             ifunc = ifBranch;
            opJ, opJal, opJr, opJalr: ifunc = ifJump;
            default:                  ifunc = ifOrder;
        endcase
    end

    // Branch condition
    always_comb begin
        case (instr)
            opBeq:   cmp = (rsData == rtData);
            opBne:   cmp = (rsData != rtData);
            default: cmp = 1'b0;
        endcase
    end

endmodule

//--- verilog/pipelineControl.sv
`timescale 1ns/1ps

module pipelineControl import memMapPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic busyI,
    input  excT  excF,
    output logic stall,
    output logic clear,
    output logic enPC,
    output logic redirect
);

    logic accept;

    // A fetch word is taken on every cycle with memory ready
    assign accept = ~busyI;

    // Wait states freeze PC and F/D together
    assign stall = busyI;

    // Address error redirects once the faulting word is taken
    assign redirect = accept && !clear && (excF == excAddrLoad);

    // PC stays put while the bubble goes in, so the handler word is kept
    assign enPC = (accept && !clear) || redirect;

    // One bubble into D right after each redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            clear <= 1'b0;
        end else begin
            clear <= redirect;
        end
    end

endmodule

//--- verilog/frontEnd.sv
`timescale 1ns/1ps

module frontEnd import isaPkg::*, memMapPkg::*; #(
    parameter wordT BOOT_ADDR    = PC_BOOT,
    parameter wordT HANDLER_ADDR = EXC_HANDLER
) (
    input  logic             clk,
    input  logic             reset,
    // Instruction memory
    output wordT             iAddr,
    input  wordT             iRData,
    input  logic             iReady,
    // Register file read
    output logic [REG_W-1:0] rsNum,
    output logic [REG_W-1:0] rtNum,
    input  wordT             rsData,
    input  wordT             rtData,
    // Decode output
    output logic             validD,
    output wordT             pcD,
    output wordT             codeD,
    output logic             bdD,
    output excT              excD
);

    opcodeT             instrD;
    ifuncT              ifuncD;
    logic               cmpD;
    logic [IMM_W-1:0]   immD;
    logic [JADDR_W-1:0] jAddrD;
    wordT               jRegD;
    logic               busyI;
    excT                excF;
    logic               stall;
    logic               clear;
    logic               enPC;
    logic               redirect;

    fetchStage #(
        .BOOT_ADDR(BOOT_ADDR)
    ) fetchUnit (
        .clk(clk),
        .reset(reset),
        .instrD(instrD),
        .ifuncD(ifuncD),
        .cmpD(cmpD),
        .immD(immD),
        .jAddrD(jAddrD),
        .jRegD(jRegD),
        .exl(redirect),
        .exnpc(HANDLER_ADDR),
        .iAddr(iAddr),
        .iRData(iRData),
        .iReady(iReady),
        .codeD(codeD),
        .pcD(pcD),
        .bdD(bdD),
        .excD(excD),
        .validD(validD),
        .stall(stall),
        .clear(clear),
        .enPC(enPC),
        .busyI(busyI),
        .excF(excF)
    );

    branchDecode decodeUnit (
        .codeD(codeD),
        .validD(validD),
        .rsData(rsData),
        .rtData(rtData),
        .rsNum(rsNum),
        .rtNum(rtNum),
        .instr(instrD),
        .ifunc(ifuncD),
        .cmp(cmpD),
        .imm(immD),
        .jAddr(jAddrD),
        .jReg(jRegD)
    );

    pipelineControl ctrlUnit (
        .clk(clk),
        .reset(reset),
        .busyI(busyI),
        .excF(excF),
        .stall(stall),
        .clear(clear),
        .enPC(enPC),
        .redirect(redirect)
    );

endmodule

//--- testbench/frontEnd_checker.sv
`timescale 1ns/1ps

module frontEnd_checker import memMapPkg::*; #(
    parameter wordT BOOT_ADDR    = PC_BOOT,
    parameter wordT HANDLER_ADDR = EXC_HANDLER
) (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic clear,
    input logic redirect,
    input logic validD,
    input wordT iAddr
);

    // No word enters D and the PC holds on an edge that stalls or clears
    noLoadOnHold: assert property (
        @(posedge clk) disable iff (reset) (stall || clear) |=> !validD && $stable(iAddr)
    ) else $error("validD strobe or PC change after a stall or clear edge");

    // Each exception redirect loads the handler and then clears D
    redirectThenClear: assert property (
        @(posedge clk) disable iff (reset) redirect |=> clear && (iAddr == HANDLER_ADDR)
    ) else $error("redirect not followed by clear at the handler address");

    bootAfterReset: assert property (
        @(posedge clk) $fell(reset) |-> (iAddr == BOOT_ADDR)
    ) else $error("PC differs from the boot address after reset");

endmodule

//--- testbench/frontEnd_tb.sv
`timescale 1ns/1ps

module frontEnd_tb import isaPkg::*, memMapPkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int IM_WORDS   = 2048;

    logic             clk    = 1'b0;
    logic             reset  = 1'b1;
    logic             iReady = 1'b0;
    wordT             iAddr;
    wordT             iRData;
    logic [REG_W-1:0] rsNum;
    logic [REG_W-1:0] rtNum;
    wordT             rsData;
    wordT             rtData;
    logic             validD;
    wordT             pcD;
    wordT             codeD;
    logic             bdD;
    excT              excD;

    wordT       imem [0:IM_WORDS-1];
    wordT       imemOffset;
    wordT       expPc[$];
    wordT       expCode[$];
    logic       expBd[$];
    excT        expExc[$];
    int         recIdx = 0;
    int         waitPlan [0:511];
    logic [8:0] pickIdx = '0;
    int         waitPick;
    int         waitLeft;

    frontEnd #(
        .BOOT_ADDR(PC_BOOT),
        .HANDLER_ADDR(EXC_HANDLER)
    ) dut_i (.*);

    bind frontEnd frontEnd_checker #(
        .BOOT_ADDR(BOOT_ADDR),
        .HANDLER_ADDR(HANDLER_ADDR)
    ) checkerI (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction memory model returning zero outside the window
    assign imemOffset = iAddr - IM_START;
    assign iRData = (iAddr < IM_START || iAddr > IM_END) ? '0 : imem[imemOffset[12:2]];

    // Register file stand-in
    assign rsData = wordT'(rsNum) * 32'd3;
    assign rtData = wordT'(rtNum) * 32'd3;

    task automatic loadInput();
        int    fd;
        int    n;
        string line;
        byte   kind;
        wordT  a;
        wordT  b;
        wordT  c;
        wordT  d;
        wordT  offset;
        // Unused words decode as a non-branch class
        foreach (imem[i]) begin
            imem[i] = 32'hfc00_0000 | (IM_START + wordT'(i) * 32'd4);
        end
        fd = $fopen("testbench/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file testbench/fetch_input.txt");
            $display("TEST FAIL");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            kind = (n > 0 && line.len() > 0) ? line[0] : "#";
            if (kind == "M" || kind == "T") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
                offset = a - IM_START;
                if (a >= IM_START && a <= IM_END) begin
                    imem[offset[12:2]] = b;
                end
                if (kind == "T" && n == 4) begin
                    expPc.push_back(a);
                    expCode.push_back(b);
                    expBd.push_back(c[0]);
                    expExc.push_back(excT'(d[4:0]));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wordCheck(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("FAILED time %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "decode trace mismatch");
        end
    endtask

    task automatic excCheck(string name, excT got, excT exp);
        if (got !== exp) begin
            $display("FAILED time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "decode trace mismatch");
        end
    endtask

    task automatic flagCheck(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED time %0t: %s = %b, expected %b", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "decode trace mismatch");
        end
    endtask

    // Each fetch gets 0 to 2 wait states before IReady
    always @(posedge clk) begin
        if (reset) begin
            iReady   <= 1'b0;
            waitLeft <= 0;
        end else if (iReady || waitLeft == 0) begin
            waitPick = waitPlan[pickIdx];
            pickIdx  <= pickIdx + 1'b1;
            iReady   <= (waitPick == 0);
            waitLeft <= waitPick;
        end else begin
            iReady   <= (waitLeft == 1);
            waitLeft <= waitLeft - 1;
        end
    end

    // D outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && validD && recIdx < expPc.size()) begin
            wordCheck("pcD", pcD, expPc[recIdx]);
            wordCheck("codeD", codeD, expCode[recIdx]);
            flagCheck("bdD", bdD, expBd[recIdx]);
            excCheck("excD", excD, expExc[recIdx]);
            recIdx <= recIdx + 1;
        end
    end

    initial begin
        void'($urandom(9094));
        foreach (waitPlan[i]) begin
            waitPlan[i] = $urandom_range(2, 0);
        end
        loadInput();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (expPc.size() == 0 || recIdx < expPc.size()) begin
            @(posedge clk);
        end
        $display("TEST PASS");
        $finish;
    end

    // Worst case is about 4 cycles per record
    initial begin
        #1;
        #((expPc.size() * 4 + 40) * CLK_PERIOD);
        $display("Timeout, the decode trace stopped at record %0d of %0d",
                 recIdx, expPc.size());
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- testbench/fetch_input.txt
# M lines give image words that taken branches skip, as M addr word
# T lines give expected decode records in order, as T pc code bd exc
M 00003010 00631821
M 00003024 00631821
M 00003028 00631821
T 00003000 00221821 0 0
T 00003004 00612021 0 0
T 00003008 10210002 0 0
T 0000300C 00422821 1 0
T 00003014 10220004 0 0
T 00003018 00213021 1 0
T 0000301C 14220003 0 0
T 00003020 00413821 1 0
T 0000302C 14630005 0 0
T 00003030 00224021 1 0
T 00003034 08000C40 0 0
T 00003038 00221821 1 0
T 00003100 0C000C80 0 0
T 00003104 00612021 1 0
T 00003200 1042FFDF 0 0
T 00003204 00422821 1 0
T 00003180 00800008 0 0
T 00003184 00213021 1 0
T 0000000C 00000000 0 4
T 00004180 00221821 0 0
T 00004184 00A0F809 0 0
T 00004188 00413821 1 0
T 0000000F 00000000 0 4
T 00004180 00221821 0 0

//--- sources.f
common/isaPkg.sv
common/memMapPkg.sv
fetch/programCounter.sv
fetch/fetchStage.sv
verilog/branchDecode.sv
verilog/pipelineControl.sv
verilog/frontEnd.sv
testbench/frontEnd_checker.sv
testbench/frontEnd_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f sources.f --top-module frontEnd_tb -Mdir obj_dir
	@out="$$(./obj_dir/VfrontEnd_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
